// File: src/l1d_pkg.sv
package l1d_pkg;

        localparam int addr_w   = 32;
        localparam int word_w   = 32;
        localparam int line_w   = 512;
        localparam int index_w  = 6;
        localparam int offset_w = 6;
        localparam int tag_w    = addr_w - index_w - offset_w;

        typedef struct packed {
                logic [tag_w-1:0]    tag;
                logic [index_w-1:0]  index;
                logic [offset_w-1:0] offset;
        } addr_fields_t;

        // one address word, seen raw or split into cache fields.
        typedef union packed {
                logic [addr_w-1:0] raw;
                addr_fields_t      f;
        } l1d_addr_t;

        typedef struct packed {
                l1d_addr_t         addr;
                logic [word_w-1:0] wdata;
                logic              we;
        } cpu_req_t;

        typedef struct packed {
                logic [word_w-1:0] rdata;   // zero for a store.
                logic              we;
        } cpu_rsp_t;

        typedef struct packed {
                logic [tag_w+index_w-1:0] line_addr;   // tag and index.
        } l2_line_req_t;

        typedef struct packed {
                l1d_addr_t         addr;
                logic [word_w-1:0] data;
        } l2_word_wr_t;

endpackage

// File: src/l1d_req_stage.sv
`timescale 1ns/100ps

module l1d_req_stage (
        input  logic                            clk,
        input  logic                            nrst,
        input  logic                            req_valid,
        output logic                            req_ready,
        input  l1d_pkg::cpu_req_t               req,
        output logic                            s1_valid,
        output l1d_pkg::cpu_req_t               s1_req,
        input  logic                            s1_ready,
        output logic [l1d_pkg::index_w-1:0]     rd_index,
        output logic [l1d_pkg::offset_w-1:0]    rd_offset
);

        logic accept;

        // free when empty or when stage 2 takes the entry this cycle.
        assign req_ready = !s1_valid || s1_ready;
        assign accept    = req_valid && req_ready;

        // a held entry keeps re-reading, so array writes show up in it.
        assign rd_index  = accept ? req.addr.f.index  : s1_req.addr.f.index;
        assign rd_offset = accept ? req.addr.f.offset : s1_req.addr.f.offset;

        always_ff @(posedge clk or negedge nrst)
        begin
                if (!nrst)
                        s1_valid <= 1'b0;
                else if (accept)
                        s1_valid <= 1'b1;
                else if (s1_ready)
                        s1_valid <= 1'b0;
        end

        always_ff @(posedge clk)
        begin
                if (accept)
                        s1_req <= req;
        end

endmodule

// File: src/l1d_tag_array.sv
`timescale 1ns/100ps

module l1d_tag_array (
        input  logic                            clk,
        input  logic                            nrst,
        input  logic [l1d_pkg::index_w-1:0]     rd_index,
        output logic [l1d_pkg::tag_w-1:0]       rd_tag,
        output logic                            rd_tag_valid,
        input  logic                            refill,
        input  logic [l1d_pkg::index_w-1:0]     fill_index,
        input  logic [l1d_pkg::tag_w-1:0]       fill_tag
);

        localparam int entries = 1 << l1d_pkg::index_w;

        logic [l1d_pkg::tag_w-1:0] tags [entries];
        logic [entries-1:0]        valid;

        always_ff @(posedge clk)
        begin
                if (refill)
                        tags[fill_index] <= fill_tag;
        end

        always_ff @(posedge clk or negedge nrst)
        begin
                if (!nrst)
                begin
                        valid        <= '0;
                        rd_tag       <= '0;
                        rd_tag_valid <= 1'b0;
                end
                else
                begin
                        if (refill)
                                valid[fill_index] <= 1'b1;
                        rd_tag       <= tags[rd_index];
                        rd_tag_valid <= valid[rd_index];   // old value on a same-edge fill.
                end
        end

endmodule

// File: src/l1d_data_array.sv
`timescale 1ns/100ps

module l1d_data_array (
        input  logic                            clk,
        input  logic                            nrst,
        input  logic [l1d_pkg::index_w-1:0]     rd_index,
        input  logic [l1d_pkg::offset_w-1:0]    rd_offset,
        output logic [l1d_pkg::word_w-1:0]      rd_word,
        input  logic                            refill,
        input  logic [l1d_pkg::index_w-1:0]     fill_index,
        input  logic [l1d_pkg::line_w-1:0]      fill_line,
        input  logic                            update,
        input  logic [l1d_pkg::index_w-1:0]     upd_index,
        input  logic [l1d_pkg::offset_w-1:0]    upd_offset,
        input  logic [l1d_pkg::word_w-1:0]      upd_word
);

        localparam int entries = 1 << l1d_pkg::index_w;
        localparam int word_aw = l1d_pkg::offset_w - 2;

        logic [l1d_pkg::line_w-1:0] lines [entries];
        logic [word_aw-1:0]         rd_sel;
        logic [word_aw-1:0]         upd_sel;

        // byte offset down to word number.
        assign rd_sel  = rd_offset[l1d_pkg::offset_w-1:2];
        assign upd_sel = upd_offset[l1d_pkg::offset_w-1:2];

        // refill writes the whole line, update only one word.
        always_ff @(posedge clk)
        begin
                if (refill)
                        lines[fill_index] <= fill_line;
                else if (update)
                        lines[upd_index][{upd_sel, 5'b00000} +: l1d_pkg::word_w] <= upd_word;
        end

        always_ff @(posedge clk or negedge nrst)
        begin
                if (!nrst)
                        rd_word <= '0;
                else
                        rd_word <= lines[rd_index][{rd_sel, 5'b00000} +: l1d_pkg::word_w];
        end

endmodule

// File: src/l1d_ctrl_stage.sv
`timescale 1ns/100ps

module l1d_ctrl_stage (
        input  logic                            clk,
        input  logic                            nrst,
        input  logic                            s1_valid,
        input  l1d_pkg::cpu_req_t               s1_req,
        output logic                            s1_ready,
        input  logic [l1d_pkg::tag_w-1:0]       rd_tag,
        input  logic                            rd_tag_valid,
        input  logic [l1d_pkg::word_w-1:0]      rd_word,
        output logic                            refill,
        output logic [l1d_pkg::index_w-1:0]     fill_index,
        output logic [l1d_pkg::tag_w-1:0]       fill_tag,
        output logic [l1d_pkg::line_w-1:0]      fill_line,
        output logic                            update,
        output logic [l1d_pkg::index_w-1:0]     upd_index,
        output logic [l1d_pkg::offset_w-1:0]    upd_offset,
        output logic [l1d_pkg::word_w-1:0]      upd_word,
        output logic                            line_req_valid,
        output l1d_pkg::l2_line_req_t           line_req,
        input  logic                            fill_valid,
        input  logic [l1d_pkg::line_w-1:0]      fill_data,
        output logic                            word_wr_valid,
        output l1d_pkg::l2_word_wr_t            word_wr,
        output logic                            rsp_valid,
        input  logic                            rsp_ready,
        output l1d_pkg::cpu_rsp_t               rsp
);

        typedef enum logic [2:0] {s_idle, s_check, s_store, s_miss, s_resp} state_t;

        state_t                         state;
        l1d_pkg::cpu_req_t              s2_req;
        logic                           s2_hit;
        logic [l1d_pkg::word_w-1:0]     s2_word;
        logic [l1d_pkg::word_w-1:0]     fill_word;
        logic                           hit;
        logic                           take;

        assign hit  = rd_tag_valid && (rd_tag == s1_req.addr.f.tag);
        assign take = s1_valid && s1_ready;

        // only a load hit frees stage 1 early; after any array write
        // the held entry must re-read first.
        assign s1_ready = (state == s_idle) ||
                          (state == s_resp && rsp_ready && !s2_req.we && s2_hit);

        assign fill_word = fill_data[{s2_req.addr.f.offset[l1d_pkg::offset_w-1:2], 5'b00000}
                                     +: l1d_pkg::word_w];

        assign refill     = (state == s_miss) && fill_valid;
        assign fill_index = s2_req.addr.f.index;
        assign fill_tag   = s2_req.addr.f.tag;
        assign fill_line  = fill_data;

        assign update     = (state == s_store) && s2_hit;   // no allocate on a store miss.
        assign upd_index  = s2_req.addr.f.index;
        assign upd_offset = s2_req.addr.f.offset;
        assign upd_word   = s2_req.wdata;

        assign word_wr_valid      = (state == s_store);
        assign word_wr.addr       = s2_req.addr;
        assign word_wr.data       = s2_req.wdata;
        assign line_req.line_addr = {s2_req.addr.f.tag, s2_req.addr.f.index};

        assign rsp_valid = (state == s_resp);

        always_ff @(posedge clk or negedge nrst)
        begin
                if (!nrst)
                begin
                        state          <= s_idle;
                        line_req_valid <= 1'b0;
                end
                else
                begin
                        line_req_valid <= 1'b0;
                        case (state)
                        s_idle:
                                if (take)
                                        state <= s_check;
                        s_check:
                                if (s2_req.we)
                                        state <= s_store;
                                else if (s2_hit)
                                        state <= s_resp;
                                else
                                begin
                                        state          <= s_miss;
                                        line_req_valid <= 1'b1;   // one-cycle pulse.
                                end
                        s_store:
                                state <= s_resp;
                        s_miss:
                                if (fill_valid)
                                        state <= s_resp;
                        s_resp:
                                if (rsp_ready)
                                        state <= take ? s_check : s_idle;
                        default:
                                state <= s_idle;
                        endcase
                end
        end

        always_ff @(posedge clk)
        begin
                if (take)
                begin
                        s2_req  <= s1_req;
                        s2_hit  <= hit;
                        s2_word <= rd_word;
                end
                case (state)
                s_check:
                        rsp <= '{rdata: s2_word, we: 1'b0};
                s_store:
                        rsp <= '{rdata: '0, we: 1'b1};
                s_miss:
                        if (fill_valid)
                                rsp <= '{rdata: fill_word, we: 1'b0};
                default:
                        rsp <= rsp;   // held until taken.
                endcase
        end

endmodule

// File: src/l2_line_mem.sv
`timescale 1ns/100ps

module l2_line_mem #(
        parameter int L2_LATENCY = 4,
        parameter int MEM_LINES  = 256
) (
        input  logic                            clk,
        input  logic                            nrst,
        input  logic                            line_req_valid,
        input  l1d_pkg::l2_line_req_t           line_req,
        output logic                            fill_valid,
        output logic [l1d_pkg::line_w-1:0]      fill_data,
        input  logic                            word_wr_valid,
        input  l1d_pkg::l2_word_wr_t            word_wr
);

        localparam int mem_aw  = $clog2(MEM_LINES);
        localparam int cnt_w   = $clog2(L2_LATENCY + 1);
        localparam int word_aw = l1d_pkg::offset_w - 2;

        logic [l1d_pkg::line_w-1:0]     mem [MEM_LINES];
        logic [mem_aw-1:0]              rd_line;
        logic [mem_aw-1:0]              wr_line;
        logic [word_aw-1:0]             wr_word;
        logic [cnt_w-1:0]               cnt;
        logic                           busy;
        logic                           fire;

        assign wr_line = word_wr.addr.raw[l1d_pkg::offset_w +: mem_aw];
        assign wr_word = word_wr.addr.raw[l1d_pkg::offset_w-1:2];
        assign fire    = busy && (cnt == 1);

        // latency counts from the request pulse, so at least 2.
        always_ff @(posedge clk or negedge nrst)
        begin
                if (!nrst)
                begin
                        busy       <= 1'b0;
                        cnt        <= '0;
                        rd_line    <= '0;
                        fill_valid <= 1'b0;
                end
                else
                begin
                        fill_valid <= fire;
                        if (line_req_valid && !busy)
                        begin
                                busy    <= 1'b1;
                                cnt     <= cnt_w'(L2_LATENCY - 1);
                                rd_line <= line_req.line_addr[mem_aw-1:0];
                        end
                        else if (fire)
                                busy <= 1'b0;
                        else if (busy)
                                cnt <= cnt - 1'b1;
                end
        end

        always_ff @(posedge clk or negedge nrst)
        begin
                if (!nrst)
                begin
                        for (int i = 0; i < MEM_LINES; i++)
                                mem[i] <= '0;
                end
                else if (word_wr_valid)
                        mem[wr_line][{wr_word, 5'b00000} +: l1d_pkg::word_w] <= word_wr.data;
        end

        always_ff @(posedge clk)
        begin
                if (fire)
                        fill_data <= mem[rd_line];
        end

endmodule

// File: src/l1d_top.sv
`timescale 1ns/100ps

module l1d_top #(
        parameter int L2_LATENCY = 4,
        parameter int MEM_LINES  = 256
) (
        input  logic                    clk,
        input  logic                    nrst,
        input  logic                    req_valid,
        output logic                    req_ready,
        input  l1d_pkg::cpu_req_t       req,
        output logic                    rsp_valid,
        input  logic                    rsp_ready,
        output l1d_pkg::cpu_rsp_t       rsp
);

        logic                           s1_valid;
        logic                           s1_ready;
        l1d_pkg::cpu_req_t              s1_req;
        logic [l1d_pkg::index_w-1:0]    rd_index;
        logic [l1d_pkg::offset_w-1:0]   rd_offset;
        logic [l1d_pkg::tag_w-1:0]      rd_tag;
        logic                           rd_tag_valid;
        logic [l1d_pkg::word_w-1:0]     rd_word;
        logic                           refill;
        logic [l1d_pkg::index_w-1:0]    fill_index;
        logic [l1d_pkg::tag_w-1:0]      fill_tag;
        logic [l1d_pkg::line_w-1:0]     fill_line;
        logic                           update;
        logic [l1d_pkg::index_w-1:0]    upd_index;
        logic [l1d_pkg::offset_w-1:0]   upd_offset;
        logic [l1d_pkg::word_w-1:0]     upd_word;
        logic                           line_req_valid;
        l1d_pkg::l2_line_req_t          line_req;
        logic                           fill_valid;
        logic [l1d_pkg::line_w-1:0]     fill_data;
        logic                           word_wr_valid;
        l1d_pkg::l2_word_wr_t           word_wr;

        l1d_req_stage u_req (.*);

        l1d_tag_array u_tag (.*);

        l1d_data_array u_data (.*);

        l1d_ctrl_stage u_ctrl (.*);

        l2_line_mem #(
                .L2_LATENCY (L2_LATENCY),
                .MEM_LINES  (MEM_LINES)
        ) u_l2 (.*);

endmodule

// File: sim/l1d_checker.sv
`timescale 1ns/100ps

module l1d_checker #(
        parameter int MEM_LINES = 256
) (
        input  logic                    clk,
        input  logic                    nrst,
        input  logic                    req_valid,
        input  logic                    req_ready,
        input  l1d_pkg::cpu_req_t       req,
        input  logic                    rsp_valid,
        input  logic                    rsp_ready,
        input  l1d_pkg::cpu_rsp_t       rsp,
        output int                      req_count,
        output int                      rsp_count,
        output int                      err_count
);

        localparam int words = MEM_LINES * 16;   // 16 words per line.

        typedef struct packed {
                logic [31:0]            addr;
                l1d_pkg::cpu_rsp_t      rsp;
        } pend_t;

        logic [31:0]    ref_mem [words];
        pend_t          pend_q [$];
        pend_t          ent;
        int             n_req;
        int             n_rsp;
        int             n_err;
        int             widx;
        bit             rst_seen;

        initial
        begin
                for (int i = 0; i < words; i++)
                        ref_mem[i] = '0;
                n_req     = 0;
                n_rsp     = 0;
                n_err     = 0;
                rst_seen  = 1'b0;
                req_count = 0;
                rsp_count = 0;
                err_count = 0;
        end

        task automatic compare_rsp(input pend_t want);
                begin
                        if (rsp.we !== want.rsp.we)
                        begin
                                n_err++;
                                $display("MISMATCH rsp.we addr %h: got %h, expected %h",
                                         want.addr, rsp.we, want.rsp.we);
                        end
                        if (rsp.rdata !== want.rsp.rdata)
                        begin
                                n_err++;
                                $display("MISMATCH rsp.rdata addr %h: got %h, expected %h",
                                         want.addr, rsp.rdata, want.rsp.rdata);
                        end
                end
        endtask

        always @(posedge clk)
        begin
                if (!nrst)
                begin
                        if (rst_seen && (rsp_valid !== 1'b0 || req_ready !== 1'b1))
                        begin
                                n_err++;
                                $display("handshake outputs not at reset values during reset");
                        end
                        rst_seen = 1'b1;
                end
                else
                begin
                        if (rsp_valid && rsp_ready)
                        begin
                                n_rsp++;
                                if (pend_q.size() == 0)
                                begin
                                        n_err++;
                                        $display("response with no matching request, rdata %h",
                                                 rsp.rdata);
                                end
                                else
                                        compare_rsp(pend_q.pop_front());
                        end
                        if (req_valid && req_ready)
                        begin
                                n_req++;
                                widx     = (req.addr.raw >> 2) % words;
                                ent.addr = req.addr.raw;
                                ent.rsp.we = req.we;
                                if (req.we)
                                begin
                                        ref_mem[widx] = req.wdata;
                                        ent.rsp.rdata = '0;   // stores answer with zero.
                                end
                                else
                                        ent.rsp.rdata = ref_mem[widx];
                                pend_q.push_back(ent);
                        end
                end
                req_count <= n_req;
                rsp_count <= n_rsp;
                err_count <= n_err;
        end

endmodule

// File: sim/tb_l1d.sv
`timescale 1ns/100ps

module tb_l1d;

        localparam int L2_LATENCY  = 4;
        localparam int MEM_LINES   = 256;
        localparam int n_vec       = 25;
        localparam int n_rand      = 40;
        localparam int watchdog_ns = (n_vec + n_rand) * (L2_LATENCY + 8) * 20 * 2;

        typedef struct packed {
                logic [3:0]     test;
                logic           we;
                logic [31:0]    addr;
                logic [31:0]    wdata;
        } vec_t;

        logic                   clk;
        logic                   nrst;
        logic                   req_valid;
        logic                   req_ready;
        l1d_pkg::cpu_req_t      req;
        logic                   rsp_valid;
        logic                   rsp_ready;
        l1d_pkg::cpu_rsp_t      rsp;
        logic                   rand_phase;
        logic [31:0]            rng;
        int                     req_count;
        int                     rsp_count;
        int                     err_count;
        vec_t                   tbl [n_vec + n_rand];

        l1d_top #(
                .L2_LATENCY (L2_LATENCY),
                .MEM_LINES  (MEM_LINES)
        ) UUT (.*);

        l1d_checker #(
                .MEM_LINES (MEM_LINES)
        ) u_chk (.*);

        function automatic logic [31:0] xorshift32(input logic [31:0] x);
                logic [31:0] y;
                begin
                        y = x ^ (x << 13);
                        y = y ^ (y >> 17);
                        y = y ^ (y << 5);
                        return y;
                end
        endfunction

        function automatic string test_name(input int id);
                case (id)
                1:       return "unwritten load";
                2:       return "refill then hits";
                3:       return "store hit";
                4:       return "store miss no-allocate";
                5:       return "eviction";
                default: return "random traffic";
                endcase
        endfunction

        task automatic load_table();
                tbl[0]  = {4'd1, 1'b0, 32'h0000_0100, 32'h0000_0000};
                tbl[1]  = {4'd1, 1'b0, 32'h0000_2a40, 32'h0000_0000};
                tbl[2]  = {4'd2, 1'b1, 32'h0000_0200, 32'ha1a1_0001};
                tbl[3]  = {4'd2, 1'b1, 32'h0000_0204, 32'ha1a1_0002};
                tbl[4]  = {4'd2, 1'b1, 32'h0000_023c, 32'ha1a1_000f};
                tbl[5]  = {4'd2, 1'b0, 32'h0000_0200, 32'h0000_0000};   // miss, refill.
                tbl[6]  = {4'd2, 1'b0, 32'h0000_0204, 32'h0000_0000};
                tbl[7]  = {4'd2, 1'b0, 32'h0000_023c, 32'h0000_0000};
                tbl[8]  = {4'd2, 1'b0, 32'h0000_0208, 32'h0000_0000};
                tbl[9]  = {4'd3, 1'b1, 32'h0000_0204, 32'hb2b2_0002};
                tbl[10] = {4'd3, 1'b0, 32'h0000_0204, 32'h0000_0000};
                tbl[11] = {4'd3, 1'b0, 32'h0000_0200, 32'h0000_0000};
                tbl[12] = {4'd4, 1'b1, 32'h0000_0480, 32'hc3c3_0020};
                tbl[13] = {4'd4, 1'b0, 32'h0000_0480, 32'h0000_0000};
                tbl[14] = {4'd4, 1'b0, 32'h0000_0484, 32'h0000_0000};
                // 0x0040 and 0x1040 share index 1.
                tbl[15] = {4'd5, 1'b1, 32'h0000_0040, 32'hd4d4_0001};
                tbl[16] = {4'd5, 1'b1, 32'h0000_1040, 32'hd4d4_1001};
                tbl[17] = {4'd5, 1'b0, 32'h0000_0040, 32'h0000_0000};
                tbl[18] = {4'd5, 1'b0, 32'h0000_1040, 32'h0000_0000};
                tbl[19] = {4'd5, 1'b1, 32'h0000_0040, 32'hd4d4_0002};
                tbl[20] = {4'd5, 1'b0, 32'h0000_0040, 32'h0000_0000};
                tbl[21] = {4'd5, 1'b1, 32'h0000_0040, 32'hd4d4_0003};
                tbl[22] = {4'd5, 1'b0, 32'h0000_0040, 32'h0000_0000};
                tbl[23] = {4'd5, 1'b0, 32'h0000_1040, 32'h0000_0000};
                tbl[24] = {4'd5, 1'b0, 32'h0000_0040, 32'h0000_0000};   // back from L2.
        endtask

        task automatic gen_random();
                for (int i = n_vec; i < n_vec + n_rand; i++)
                begin
                        rng = xorshift32(rng);
                        // 16 indexes, 4 tags, so hits and evictions both occur.
                        tbl[i] = {4'd6, rng[31], rng & 32'h0000_3f3c, 32'h0};
                        rng = xorshift32(rng);
                        tbl[i].wdata = rng;
                end
        endtask

        task automatic send_req(input vec_t v);
                l1d_pkg::cpu_req_t r;
                begin
                        r.addr.raw = v.addr;
                        r.wdata    = v.wdata;
                        r.we       = v.we;
                        req_valid <= 1'b1;
                        req       <= r;
                        @(posedge clk);
                        while (!req_ready)
                                @(posedge clk);
                end
        endtask

        task automatic run_test(input int id);
                int e0;
                int sent;
                begin
                        e0   = err_count;
                        sent = 0;
                        for (int i = 0; i < n_vec + n_rand; i++)
                        begin
                                if (tbl[i].test == id)
                                begin
                                        send_req(tbl[i]);
                                        sent++;
                                end
                        end
                        req_valid <= 1'b0;
                        @(posedge clk);   // let the counts catch up.
                        while (rsp_count != req_count)
                                @(posedge clk);
                        $display("test %0d %s: %s, %0d requests", id, test_name(id),
                                 (err_count == e0) ? "ok" : "FAILED", sent);
                end
        endtask

        initial
        begin
                clk = 1'b0;
                forever #10 clk = ~clk;
        end

        // random back-pressure on the response channel.
        always @(posedge clk)
        begin
                if (rand_phase)
                begin
                        rng = xorshift32(rng);
                        rsp_ready <= (rng[1:0] != 2'b00);
                end
                else
                        rsp_ready <= 1'b1;
        end

        initial
        begin
                #(watchdog_ns);
                $display("timeout: responses still missing after %0d ns", watchdog_ns);
                $display("Regression failed");
                $finish;
        end

        initial
        begin
                nrst       = 1'b0;
                req_valid  = 1'b0;
                req        = '0;
                rsp_ready  = 1'b1;
                rand_phase = 1'b0;
                rng        = 32'd47;
                load_table();
                gen_random();
                repeat (10) @(posedge clk);
                nrst <= 1'b1;
                @(posedge clk);
                for (int t = 1; t <= 5; t++)
                        run_test(t);
                rand_phase <= 1'b1;
                run_test(6);
                rand_phase <= 1'b0;
                @(posedge clk);
                $display("summary: %0d requests, %0d responses, %0d errors",
                         req_count, rsp_count, err_count);
                if (err_count == 0 && req_count == rsp_count)
                        $display("Regression passed");
                else
                        $display("Regression failed");
                $finish;
        end

endmodule

// File: filelist.f
src/l1d_pkg.sv
src/l1d_req_stage.sv
src/l1d_tag_array.sv
src/l1d_data_array.sv
src/l1d_ctrl_stage.sv
src/l2_line_mem.sv
src/l1d_top.sv
sim/l1d_checker.sv
sim/tb_l1d.sv
